//--- verification/dma_rd_vectors.txt
00001000 16 0 1
00001f80 16 0 2
00000ff0 40 0 4
00003000 33 1 3
00000000 0 0 0
0000fc08 300 0 19
00010e40 100 0 8
7fffff00 32 0 2
00002ff0 2 1 2

//--- list.f
hw/dma_rd_pkg.sv
hw/dma_rd_regs.sv
hw/dma_rd_ctrl.sv
hw/burst_planner.sv
hw/axi_addr_cross4k.sv
hw/rd_data_sum.sv
hw/dma_rd_top.sv
verification/tb_clk_gen.sv
verification/tb_dma_rd.sv

//--- verification/tb_dma_rd.sv
`timescale 1ns/1ns

module tb_dma_rd import dma_rd_pkg::*; ();

    logic aclk;
    logic aresetn;

    // AXI4-Lite master side
    logic              s_awvalid = 1'b0;
    logic [ADDR_W-1:0] s_awaddr  = '0;
    logic              s_wvalid  = 1'b0;
    logic [LITE_W-1:0] s_wdata   = '0;
    logic [3:0]        s_wstrb   = '0;
    logic              s_bready  = 1'b1;
    logic              s_arvalid = 1'b0;
    logic [ADDR_W-1:0] s_araddr  = '0;
    logic              s_rready  = 1'b1;
    logic              s_awready;
    logic              s_wready;
    logic              s_bvalid;
    logic [1:0]        s_bresp;
    logic              s_arready;
    logic              s_rvalid;
    logic [LITE_W-1:0] s_rdata;
    logic [1:0]        s_rresp;

    // AXI4 memory side
    logic              m_arready = 1'b0;
    logic              m_rvalid  = 1'b0;
    logic [DATA_W-1:0] m_rdata   = '0;
    logic [1:0]        m_rresp   = '0;
    logic              m_rlast   = 1'b0;
    logic              m_arvalid;
    logic [ID_W-1:0]   m_arid;
    logic [ADDR_W-1:0] m_araddr;
    logic [3:0]        m_arlen;
    logic [2:0]        m_arsize;
    logic [1:0]        m_arburst;
    logic              m_rready;

    integer      seed = 5;
    logic [31:0] next_addr;
    int          ar_seen;
    int          beats_seen;
    int          inflight;
    int          beat_idx;
    int          inject_err;
    logic [31:0] pend_addr[$];
    int          pend_beats[$];

    tb_clk_gen u_clk_gen (
        .o_aclk    (aclk),
        .o_aresetn (aresetn)
    );

    dma_rd_top uut (
        .i_aclk      (aclk),
        .i_aresetn   (aresetn),
        .i_s_awvalid (s_awvalid),
        .i_s_awaddr  (s_awaddr),
        .o_s_awready (s_awready),
        .i_s_wvalid  (s_wvalid),
        .i_s_wdata   (s_wdata),
        .i_s_wstrb   (s_wstrb),
        .o_s_wready  (s_wready),
        .o_s_bvalid  (s_bvalid),
        .o_s_bresp   (s_bresp),
        .i_s_bready  (s_bready),
        .i_s_arvalid (s_arvalid),
        .i_s_araddr  (s_araddr),
        .o_s_arready (s_arready),
        .o_s_rvalid  (s_rvalid),
        .o_s_rdata   (s_rdata),
        .o_s_rresp   (s_rresp),
        .i_s_rready  (s_rready),
        .o_m_arvalid (m_arvalid),
        .o_m_arid    (m_arid),
        .o_m_araddr  (m_araddr),
        .o_m_arlen   (m_arlen),
        .o_m_arsize  (m_arsize),
        .o_m_arburst (m_arburst),
        .i_m_arready (m_arready),
        .i_m_rvalid  (m_rvalid),
        .i_m_rdata   (m_rdata),
        .i_m_rresp   (m_rresp),
        .i_m_rlast   (m_rlast),
        .o_m_rready  (m_rready)
    );

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Fail at %0t ns: %s (got %0h, expected %0h)", $time, what, actual,
                     expected);
            $display("Finished with errors");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "run aborted");
    endtask

    // ========================================================================
    // AXI4-Lite register driver
    // ========================================================================
    task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        s_awvalid <= 1'b1;
        s_awaddr  <= {24'h0, addr};
        s_wvalid  <= 1'b1;
        s_wdata   <= data;
        s_wstrb   <= 4'hF;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            if (n > 50) abort_run("timeout: register write address and data not accepted");
        end while (!(s_awready && s_wready));
        s_awvalid <= 1'b0;
        s_wvalid  <= 1'b0;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            if (n > 50) abort_run("timeout: no write response from the register block");
        end while (!s_bvalid);
        check(s_bresp, 2'b00, "register write response");
    endtask

    task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        s_arvalid <= 1'b1;
        s_araddr  <= {24'h0, addr};
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            if (n > 50) abort_run("timeout: register read address not accepted");
        end while (!s_arready);
        s_arvalid <= 1'b0;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
            if (n > 50) abort_run("timeout: no read data from the register block");
        end while (!s_rvalid);
        data = s_rdata;
        check(s_rresp, 2'b00, "register read response");
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int n;
        st = '0;
        n = 0;
        while (!st[1]) begin
            reg_read(REG_STATUS, st);
            n++;
            if (n > 4000) abort_run("timeout: transfer never reported done");
        end
    endtask

    // each beat at B carries B, B+4, B+8, B+12
    function automatic logic [31:0] expected_sum(input logic [31:0] src, input int beats);
        logic [31:0] base;
        logic [31:0] sum;
        base = {src[31:4], 4'h0};
        sum = '0;
        for (int i = 0; i < beats; i++) begin
            for (int w = 0; w < 4; w++) begin
                sum = sum + base + 32'(i * 16 + w * 4);
            end
        end
        return sum;
    endfunction

    task automatic record_ar(input logic [31:0] addr, input logic [3:0] len);
        int n;
        logic [31:0] last;
        n = int'(len) + 1;
        last = addr + 32'(n * BEAT_BYTES) - 32'd1;
        check(addr, next_addr, "AR address not contiguous");
        check(last[12], addr[12], "AR crosses a 4 KB boundary");
        check(m_arid, 4'h0, "arid");
        check(m_arsize, 3'd4, "arsize");
        check(m_arburst, 2'b01, "arburst");
        next_addr = addr + 32'(n * BEAT_BYTES);
        beats_seen += n;
        ar_seen++;
        inflight++;
        check(inflight > MAX_OUTSTANDING, 1'b0, "more ARs in flight than allowed");
        pend_addr.push_back(addr);
        pend_beats.push_back(n);
    endtask

    // ========================================================================
    // AXI4 read memory model
    // ========================================================================
    always @(posedge aclk) begin : mem_model
        logic [31:0] b;
        if (aresetn) begin
            if (m_arvalid && m_arready) begin
                record_ar(m_araddr, m_arlen);
            end
            if (m_rvalid && m_rready) begin
                beat_idx++;
                if (m_rlast) begin
                    pend_addr.delete(0);
                    pend_beats.delete(0);
                    beat_idx = 0;
                    inflight--;
                end
            end
            m_arready <= (($random(seed) & 3) != 0);
            // a presented beat stays until it is taken
            if (!m_rvalid || m_rready) begin
                if ((pend_addr.size() > 0) && (($random(seed) & 3) != 0)) begin
                    b = pend_addr[0] + 32'(beat_idx * BEAT_BYTES);
                    m_rvalid <= 1'b1;
                    m_rdata  <= {b + 32'd12, b + 32'd8, b + 32'd4, b};
                    m_rlast  <= (beat_idx == pend_beats[0] - 1);
                    m_rresp  <= (inject_err != 0) ? 2'b10 : RESP_OKAY;
                    inject_err = 0;
                end else begin
                    m_rvalid <= 1'b0;
                end
            end
        end
    end

    initial begin : main
        int          fd;
        int          n;
        logic [31:0] v_addr;
        int          v_beats;
        int          v_err;
        int          v_exp_ar;
        logic [31:0] rd;
        inflight = 0;
        beat_idx = 0;
        inject_err = 0;
        n = 0;
        while (aresetn !== 1'b1) begin
            @(posedge aclk);
            n++;
            if (n > 20) abort_run("timeout: reset was never released");
        end
        reg_read(REG_STATUS, rd);
        check(rd, 32'h0, "STATUS after reset");

        fd = $fopen("verification/dma_rd_vectors.txt", "r");
        if (fd == 0) abort_run("cannot open verification/dma_rd_vectors.txt");
        while ($fscanf(fd, "%h %d %d %d\n", v_addr, v_beats, v_err, v_exp_ar) == 4) begin
            reg_write(REG_SRC, v_addr);
            reg_write(REG_BEATS, 32'(v_beats));
            reg_read(REG_SRC, rd);
            check(rd, v_addr, "SRC readback");
            reg_read(REG_BEATS, rd);
            check(rd, 32'(v_beats), "BEATS readback");
            next_addr = {v_addr[31:4], 4'h0};
            ar_seen = 0;
            beats_seen = 0;
            inject_err = v_err;
            reg_write(REG_CTRL, 32'h1);
            wait_done();
            reg_read(REG_STATUS, rd);
            check(rd, (v_err != 0) ? 32'h6 : 32'h2, "STATUS after done");
            check(32'(ar_seen), 32'(v_exp_ar), "number of ARs");
            check(32'(beats_seen), 32'(v_beats), "beats covered by ARs");
            reg_read(REG_SUM, rd);
            check(rd, expected_sum(v_addr, v_beats), "checksum");
        end
        if (!$feof(fd)) abort_run("malformed line in the vector file");
        $fclose(fd);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic o_aclk,
    output logic o_aresetn
);

    // 40 ns period
    initial begin
        o_aclk = 1'b0;
        forever begin
            #20 o_aclk = ~o_aclk;
        end
    end

    // reset held low for five rising edges
    initial begin
        o_aresetn = 1'b0;
        repeat (5) @(posedge o_aclk);
        o_aresetn <= 1'b1;
    end

endmodule

//--- hw/dma_rd_top.sv
`timescale 1ns/1ns

module dma_rd_top import dma_rd_pkg::*; (
    input  logic              i_aclk,
    input  logic              i_aresetn,
    // AXI4-Lite slave
    input  logic              i_s_awvalid,
    input  logic [ADDR_W-1:0] i_s_awaddr,
    output logic              o_s_awready,
    input  logic              i_s_wvalid,
    input  logic [LITE_W-1:0] i_s_wdata,
    input  logic [3:0]        i_s_wstrb,
    output logic              o_s_wready,
    output logic              o_s_bvalid,
    output logic [1:0]        o_s_bresp,
    input  logic              i_s_bready,
    input  logic              i_s_arvalid,
    input  logic [ADDR_W-1:0] i_s_araddr,
    output logic              o_s_arready,
    output logic              o_s_rvalid,
    output logic [LITE_W-1:0] o_s_rdata,
    output logic [1:0]        o_s_rresp,
    input  logic              i_s_rready,
    // AXI4 read master
    output logic              o_m_arvalid,
    output logic [ID_W-1:0]   o_m_arid,
    output logic [ADDR_W-1:0] o_m_araddr,
    output logic [3:0]        o_m_arlen,
    output logic [2:0]        o_m_arsize,
    output logic [1:0]        o_m_arburst,
    input  logic              i_m_arready,
    input  logic              i_m_rvalid,
    input  logic [DATA_W-1:0] i_m_rdata,
    input  logic [1:0]        i_m_rresp,
    input  logic              i_m_rlast,
    output logic              o_m_rready
);

    logic        start;
    logic        load;
    logic        clear;
    logic        plan_empty;
    logic        rd_idle;
    logic        err_seen;
    logic        req_valid;
    logic        req_ready;
    logic        ar_issued;
    logic        burst_retired;
    logic [31:0] checksum;
    dma_cfg_t    cfg;
    dma_status_t status;
    burst_req_t  req;

    dma_rd_regs u_regs (
        .i_aclk     (i_aclk),
        .i_aresetn  (i_aresetn),
        .i_awvalid  (i_s_awvalid),
        .i_awaddr   (i_s_awaddr),
        .o_awready  (o_s_awready),
        .i_wvalid   (i_s_wvalid),
        .i_wdata    (i_s_wdata),
        .i_wstrb    (i_s_wstrb),
        .o_wready   (o_s_wready),
        .o_bvalid   (o_s_bvalid),
        .o_bresp    (o_s_bresp),
        .i_bready   (i_s_bready),
        .i_arvalid  (i_s_arvalid),
        .i_araddr   (i_s_araddr),
        .o_arready  (o_s_arready),
        .o_rvalid   (o_s_rvalid),
        .o_rdata    (o_s_rdata),
        .o_rresp    (o_s_rresp),
        .i_rready   (i_s_rready),
        .i_status   (status),
        .i_checksum (checksum),
        .o_start    (start),
        .o_cfg      (cfg)
    );

    dma_rd_ctrl u_ctrl (
        .i_aclk       (i_aclk),
        .i_aresetn    (i_aresetn),
        .i_start      (start),
        .i_plan_empty (plan_empty),
        .i_rd_idle    (rd_idle),
        .i_err_seen   (err_seen),
        .o_load       (load),
        .o_clear      (clear),
        .o_status     (status)
    );

    burst_planner u_planner (
        .i_aclk       (i_aclk),
        .i_aresetn    (i_aresetn),
        .i_load       (load),
        .i_cfg        (cfg),
        .i_req_ready  (req_ready),
        .o_req_valid  (req_valid),
        .o_req        (req),
        .o_plan_empty (plan_empty)
    );

    axi_addr_cross4k u_cross4k (
        .i_aclk          (i_aclk),
        .i_aresetn       (i_aresetn),
        .i_req_valid     (req_valid),
        .i_req           (req),
        .o_req_ready     (req_ready),
        .o_ar_issued     (ar_issued),
        .i_burst_retired (burst_retired),
        .o_arvalid       (o_m_arvalid),
        .o_arid          (o_m_arid),
        .o_araddr        (o_m_araddr),
        .o_arlen         (o_m_arlen),
        .o_arsize        (o_m_arsize),
        .o_arburst       (o_m_arburst),
        .i_arready       (i_m_arready)
    );

    rd_data_sum u_data_sum (
        .i_aclk          (i_aclk),
        .i_aresetn       (i_aresetn),
        .i_clear         (clear),
        .i_busy          (status.busy),
        .i_ar_issued     (ar_issued),
        .i_rvalid        (i_m_rvalid),
        .i_rdata         (i_m_rdata),
        .i_rresp         (i_m_rresp),
        .i_rlast         (i_m_rlast),
        .o_rready        (o_m_rready),
        .o_burst_retired (burst_retired),
        .o_rd_idle       (rd_idle),
        .o_err_seen      (err_seen),
        .o_checksum      (checksum)
    );

endmodule

//--- hw/rd_data_sum.sv
`timescale 1ns/1ns

module rd_data_sum import dma_rd_pkg::*; (
    input  logic              i_aclk,
    input  logic              i_aresetn,
    input  logic              i_clear,
    input  logic              i_busy,
    input  logic              i_ar_issued,
    input  logic              i_rvalid,
    input  logic [DATA_W-1:0] i_rdata,
    input  logic [1:0]        i_rresp,
    input  logic              i_rlast,
    output logic              o_rready,
    output logic              o_burst_retired,
    output logic              o_rd_idle,
    output logic              o_err_seen,
    output logic [31:0]       o_checksum
);

    logic              beat;
    logic [31:0]       beat_sum;
    logic [31:0]       sum_q;
    logic [OUTS_W-1:0] pending_q;
    logic              err_q;

    assign o_rready        = i_busy;
    assign beat            = i_rvalid && o_rready;
    assign o_burst_retired = beat && i_rlast;
    assign o_rd_idle       = (pending_q == '0);
    assign o_err_seen      = err_q;
    assign o_checksum      = sum_q;

    // word sum of one beat, wraps at 32 bits
    always_comb begin
        beat_sum = '0;
        for (int w = 0; w < DATA_W / 32; w++) begin
            beat_sum = beat_sum + i_rdata[32*w +: 32];
        end
    end

    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            sum_q     <= '0;
            pending_q <= '0;
            err_q     <= 1'b0;
        end else if (i_clear) begin
            sum_q     <= '0;
            pending_q <= '0;
            err_q     <= 1'b0;
        end else begin
            if (beat) begin
                sum_q <= sum_q + beat_sum;
            end
            // one R burst expected per AR
            pending_q <= pending_q + OUTS_W'(i_ar_issued) - OUTS_W'(o_burst_retired);
            if (beat && (i_rresp != RESP_OKAY)) begin
                err_q <= 1'b1;
            end
        end
    end

endmodule

//--- hw/axi_addr_cross4k.sv
`timescale 1ns/1ns

module axi_addr_cross4k import dma_rd_pkg::*; (
    input  logic              i_aclk,
    input  logic              i_aresetn,
    // request from the planner
    input  logic              i_req_valid,
    input  burst_req_t        i_req,
    output logic              o_req_ready,
    // bookkeeping with the data side
    output logic              o_ar_issued,
    input  logic              i_burst_retired,
    // AXI AR channel
    output logic              o_arvalid,
    output logic [ID_W-1:0]   o_arid,
    output logic [ADDR_W-1:0] o_araddr,
    output logic [3:0]        o_arlen,
    output logic [2:0]        o_arsize,
    output logic [1:0]        o_arburst,
    input  logic              i_arready
);

    split_state_e      state_q;
    split_state_e      state_d;
    logic [ADDR_W-1:0] burst_end;
    logic              cross_4k;
    logic [3:0]        first_len;
    logic [ADDR_W-1:0] last_addr;
    logic [3:0]        last_len;
    logic [OUTS_W-1:0] outstanding_q;
    logic              at_limit;
    logic              ar_hs;

    assign o_arid    = AXI_ID;
    assign o_arsize  = AXI_SIZE;
    assign o_arburst = AXI_BURST_INCR;

    // ========================================================================
    // 4 KB crossing detect and split parts
    // ========================================================================
    assign burst_end = i_req.addr + ({ADDR_W'(i_req.len) + 1'b1} << 4) - 1'b1;
    assign cross_4k  = i_req.addr[12] ^ burst_end[12];
    // beats left up to the boundary, minus one
    assign first_len = 4'(8'hFF - i_req.addr[11:4]);
    assign last_addr = {burst_end[ADDR_W-1:12], 12'h000};
    assign last_len  = i_req.len - first_len - 4'd1;

    assign at_limit    = (outstanding_q >= OUTS_W'(MAX_OUTSTANDING));
    assign ar_hs       = o_arvalid && i_arready;
    assign o_ar_issued = ar_hs;

    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            state_q       <= SPLIT_IDLE;
            outstanding_q <= '0;
        end else begin
            state_q <= state_d;
            case ({ar_hs, i_burst_retired})
                2'b10:   outstanding_q <= outstanding_q + 1'b1;
                2'b01:   outstanding_q <= outstanding_q - 1'b1;
                default: outstanding_q <= outstanding_q;
            endcase
        end
    end

    always_comb begin
        state_d     = state_q;
        o_arvalid   = 1'b0;
        o_araddr    = i_req.addr;
        o_arlen     = i_req.len;
        o_req_ready = 1'b0;
        case (state_q)
            SPLIT_IDLE: begin
                // whole burst goes out in the same cycle
                o_arvalid   = i_req_valid && !cross_4k && !at_limit;
                o_req_ready = ar_hs;
                if (i_req_valid && cross_4k) begin
                    state_d = SPLIT_FST;
                end
            end
            SPLIT_FST: begin
                o_arvalid = i_req_valid && !at_limit;
                o_arlen   = first_len;
                if (ar_hs) begin
                    state_d = SPLIT_LST;
                end
            end
            SPLIT_LST: begin
                o_arvalid   = !at_limit;
                o_araddr    = last_addr;
                o_arlen     = last_len;
                o_req_ready = ar_hs;
                if (ar_hs) begin
                    state_d = SPLIT_IDLE;
                end
            end
            default: begin
                state_d = SPLIT_IDLE;
            end
        endcase
    end

endmodule

//--- hw/burst_planner.sv
`timescale 1ns/1ns

module burst_planner import dma_rd_pkg::*; (
    input  logic       i_aclk,
    input  logic       i_aresetn,
    input  logic       i_load,
    input  dma_cfg_t   i_cfg,
    input  logic       i_req_ready,
    output logic       o_req_valid,
    output burst_req_t o_req,
    output logic       o_plan_empty
);

    logic [ADDR_W-1:0]  addr_q;
    logic [BEATS_W-1:0] remain_q;
    logic [4:0]         burst_beats;
    logic               hs;

    // up to MAX_BURST beats per request
    assign burst_beats = (remain_q >= BEATS_W'(MAX_BURST)) ? 5'(MAX_BURST) : remain_q[4:0];

    assign o_req_valid  = (remain_q != '0);
    assign o_plan_empty = (remain_q == '0);
    assign o_req.addr   = addr_q;
    assign o_req.len    = 4'(burst_beats - 5'd1);

    assign hs = o_req_valid && i_req_ready;

    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            remain_q <= '0;
        end else if (i_load) begin
            remain_q <= i_cfg.beats;
        end else if (hs) begin
            remain_q <= remain_q - BEATS_W'(burst_beats);
        end
    end

    // low address bits dropped as transfers are beat aligned
    always_ff @(posedge i_aclk) begin
        if (i_load) begin
            addr_q <= {i_cfg.src_addr[ADDR_W-1:4], 4'h0};
        end else if (hs) begin
            addr_q <= addr_q + ADDR_W'(burst_beats) * ADDR_W'(BEAT_BYTES);
        end
    end

endmodule

//--- hw/dma_rd_ctrl.sv
`timescale 1ns/1ns

module dma_rd_ctrl import dma_rd_pkg::*; (
    input  logic        i_aclk,
    input  logic        i_aresetn,
    input  logic        i_start,
    input  logic        i_plan_empty,
    input  logic        i_rd_idle,
    input  logic        i_err_seen,
    output logic        o_load,
    output logic        o_clear,
    output dma_status_t o_status
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        launch;

    // a new transfer may start from idle or after a finished one
    assign launch  = i_start && ((state_q == IDLE) || (state_q == DONE));
    assign o_load  = launch;
    assign o_clear = launch;

    // ========================================================================
    // state machine
    // ========================================================================
    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (launch) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                // an empty transfer skips the drain step
                if (i_plan_empty && i_rd_idle) begin
                    state_d = DONE;
                end else if (i_plan_empty) begin
                    state_d = DRAIN;
                end
            end
            DRAIN: begin
                if (i_rd_idle) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (launch) begin
                    state_d = RUN;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign o_status.busy = (state_q == RUN) || (state_q == DRAIN);
    assign o_status.done = (state_q == DONE);
    // sticky in the data path and cleared on start
    assign o_status.err  = i_err_seen;

endmodule

//--- hw/dma_rd_regs.sv
`timescale 1ns/1ns

module dma_rd_regs import dma_rd_pkg::*; (
    input  logic              i_aclk,
    input  logic              i_aresetn,
    // write address and data
    input  logic              i_awvalid,
    input  logic [ADDR_W-1:0] i_awaddr,
    output logic              o_awready,
    input  logic              i_wvalid,
    input  logic [LITE_W-1:0] i_wdata,
    input  logic [3:0]        i_wstrb,
    output logic              o_wready,
    // write response
    output logic              o_bvalid,
    output logic [1:0]        o_bresp,
    input  logic              i_bready,
    // read address and data
    input  logic              i_arvalid,
    input  logic [ADDR_W-1:0] i_araddr,
    output logic              o_arready,
    output logic              o_rvalid,
    output logic [LITE_W-1:0] o_rdata,
    output logic [1:0]        o_rresp,
    input  logic              i_rready,
    // engine side
    input  dma_status_t       i_status,
    input  logic [31:0]       i_checksum,
    output logic              o_start,
    output dma_cfg_t          o_cfg
);

    logic        wr_en;
    logic        rd_en;
    logic        bvalid_q;
    logic        rvalid_q;
    logic        start_q;
    dma_cfg_t    cfg_q;
    logic [LITE_W-1:0] rdata_q;
    logic [LITE_W-1:0] rd_mux;

    // aw and w taken together with one write in flight
    assign wr_en     = i_awvalid && i_wvalid && !bvalid_q;
    assign o_awready = wr_en;
    assign o_wready  = wr_en;
    assign o_bvalid  = bvalid_q;
    assign o_bresp   = RESP_OKAY;

    assign o_arready = !rvalid_q;
    assign rd_en     = i_arvalid && !rvalid_q;
    assign o_rvalid  = rvalid_q;
    assign o_rdata   = rdata_q;
    assign o_rresp   = RESP_OKAY;

    assign o_start = start_q;
    assign o_cfg   = cfg_q;

    always_ff @(posedge i_aclk or negedge i_aresetn) begin
        if (!i_aresetn) begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            start_q  <= 1'b0;
            cfg_q    <= '0;
        end else begin
            if (wr_en) begin
                bvalid_q <= 1'b1;
            end else if (i_bready) begin
                bvalid_q <= 1'b0;
            end
            if (rd_en) begin
                rvalid_q <= 1'b1;
            end else if (i_rready) begin
                rvalid_q <= 1'b0;
            end
            // go bit is ignored while a transfer runs
            start_q <= wr_en && (i_awaddr[7:0] == REG_CTRL) && i_wstrb[0] &&
                       i_wdata[0] && !i_status.busy;
            if (wr_en && (i_awaddr[7:0] == REG_SRC)) begin
                for (int b = 0; b < 4; b++) begin
                    if (i_wstrb[b]) begin
                        cfg_q.src_addr[8*b +: 8] <= i_wdata[8*b +: 8];
                    end
                end
            end
            if (wr_en && (i_awaddr[7:0] == REG_BEATS)) begin
                if (i_wstrb[0]) begin
                    cfg_q.beats[7:0] <= i_wdata[7:0];
                end
                if (i_wstrb[1]) begin
                    cfg_q.beats[BEATS_W-1:8] <= i_wdata[BEATS_W-1:8];
                end
            end
        end
    end

    // status bits from bit 0 up are busy, done and err
    always_comb begin
        case (i_araddr[7:0])
            REG_CTRL:   rd_mux = '0;
            REG_SRC:    rd_mux = cfg_q.src_addr;
            REG_BEATS:  rd_mux = LITE_W'(cfg_q.beats);
            REG_STATUS: rd_mux = LITE_W'({i_status.err, i_status.done, i_status.busy});
            REG_SUM:    rd_mux = i_checksum;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (rd_en) begin
            rdata_q <= rd_mux;
        end
    end

endmodule

//--- hw/dma_rd_pkg.sv
package dma_rd_pkg;

    // ========================================================================
    // bus geometry
    // ========================================================================
    localparam int ADDR_W          = 32;
    localparam int DATA_W          = 128;
    localparam int LITE_W          = 32;
    localparam int BEAT_BYTES      = 16;
    localparam logic [2:0] AXI_SIZE = 3'd4;
    localparam int MAX_BURST       = 16;
    localparam int BEATS_W         = 12;
    localparam int MAX_OUTSTANDING = 4;
    // wide enough to hold 0..MAX_OUTSTANDING
    localparam int OUTS_W          = 3;
    localparam int ID_W            = 4;
    localparam logic [ID_W-1:0] AXI_ID = '0;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [1:0] RESP_OKAY      = 2'b00;

    // ========================================================================
    // register map
    // ========================================================================
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_SRC    = 8'h04;
    localparam logic [7:0] REG_BEATS  = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_SUM    = 8'h10;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } ctrl_state_e;

    typedef enum logic [1:0] {
        SPLIT_IDLE,
        SPLIT_FST,
        SPLIT_LST
    } split_state_e;

    // len is beats minus one, as on arlen
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        len;
    } burst_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  src_addr;
        logic [BEATS_W-1:0] beats;
    } dma_cfg_t;

    typedef struct packed {
        logic busy;
        logic done;
        logic err;
    } dma_status_t;

endpackage
